// File: compile.f
verilog/stats_pkg.sv
verilog/handshake_counter_bank.sv
verilog/pkt_flag_classifier.sv
verilog/fill_watermark.sv
verilog/status_regfile.sv
verilog/pipeline_stats.sv
testbench/tb_pipeline_stats.sv

// File: testbench/tb_pipeline_stats.sv
`timescale 1ns/1ps

module tb_pipeline_stats;
    import stats_pkg::*;

    localparam int NUM_ROWS = 40;

    typedef struct packed {
        pkt_tap_t  [NUM_PKT_TAPS-1:0]  pkt;
        meta_tap_t [NUM_META_TAPS-1:0] meta;
        dm_meta_tap_t                  dm;
        fill_levels_t                  fill;
    } stim_row_t;

    typedef struct packed {
        logic        rd;
        logic [29:0] addr;
    } read_slot_t;

    logic        clk_status;
    logic        rst;
    stim_row_t   cur_row;
    logic [29:0] status_addr;
    logic        status_read;
    stat_word_t  status_readdata;
    logic        status_readdata_valid;

    stim_row_t   rows [NUM_ROWS];
    read_slot_t  slots [$];
    stat_word_t  exp_stats [NUM_STATS];
    stat_idx_e   pkt_map [NUM_PKT_TAPS] = '{IN_PKT, OUT_PKT, PCIE_PKT};
    stat_idx_e   meta_map [NUM_META_TAPS] = '{INCOMP_META, PARSER_META, FD_IN, FD_OUT,
                                              EMPTYLIST_IN, EMPTYLIST_OUT, PCIE_META};
    integer      seed;
    int          errors;
    int          num_reads;
    int          reset_reads_end;
    int          cycles;
    int          cycle_limit;

    pipeline_stats dut_i (
        .clk_status            (clk_status),
        .rst                   (rst),
        .eth_in                (cur_row.pkt[0]),
        .eth_out               (cur_row.pkt[1]),
        .pcie_pkt              (cur_row.pkt[2]),
        .incomp_meta           (cur_row.meta[0]),
        .parser_meta           (cur_row.meta[1]),
        .fd_in                 (cur_row.meta[2]),
        .fd_out                (cur_row.meta[3]),
        .emptylist_in          (cur_row.meta[4]),
        .emptylist_out         (cur_row.meta[5]),
        .pcie_meta             (cur_row.meta[6]),
        .dm_meta               (cur_row.dm),
        .fill_levels           (cur_row.fill),
        .status_addr           (status_addr),
        .status_read           (status_read),
        .status_readdata       (status_readdata),
        .status_readdata_valid (status_readdata_valid)
    );

    initial begin
        clk_status = 1'b0;
        forever #5 clk_status = ~clk_status;
    end

    task automatic check_value(input string what, input stat_word_t got, input stat_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s returned %h, expected %h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////
    task automatic build_rows();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;
        for (int i = 0; i < NUM_ROWS; i++) begin
            rows[i] = '0;
        end
        // eth_out without ready, reserved flag accepted
        rows[0].pkt  = {3'b000, 3'b101, 3'b111};
        rows[0].dm   = 4'b1111;
        rows[0].fill = {10'd100, 10'd200, 10'd300};
        // eth_out without eop, every meta tap transfers, peaks
        rows[1].pkt  = {3'b000, 3'b110, 3'b010};
        rows[1].meta = '1;
        rows[1].dm   = 4'b1100;
        rows[1].fill = {10'd480, 10'd512, 10'd350};
        // Levels fall below the peaks
        rows[2].pkt  = {3'b111, 3'b000, 3'b010};
        rows[2].dm   = 4'b1001;
        rows[2].fill = {10'd10, 10'd20, 10'd30};
        // Meta valid without ready
        rows[3].pkt  = {3'b000, 3'b111, 3'b010};
        rows[3].meta = 14'b10101010101010;
        rows[3].dm   = 4'b1110;
        // Meta ready without valid and an accepted drop flag
        rows[4].pkt  = {3'b000, 3'b000, 3'b010};
        rows[4].meta = 14'b01010101010101;
        rows[4].dm   = 4'b1101;
        for (int i = 5; i < NUM_ROWS; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            r3 = $random(seed);
            r4 = $random(seed);
            rows[i].pkt  = r1[8:0];
            rows[i].meta = r1[22:9];
            rows[i].dm   = r1[26:23];
            rows[i].fill = {fill_level_t'(r2 % 513), fill_level_t'(r3 % 513),
                            fill_level_t'(r4 % 513)};
            // Ingress never back-pressures
            rows[i].pkt[0].ready = 1'b1;
        end
    endtask

    function automatic void update_model(input stim_row_t row);
        for (int i = 0; i < NUM_PKT_TAPS; i++) begin
            if (row.pkt[i].valid && row.pkt[i].ready && row.pkt[i].eop) begin
                exp_stats[pkt_map[i]]++;
            end
        end
        for (int i = 0; i < NUM_META_TAPS; i++) begin
            if (row.meta[i].valid && row.meta[i].ready) begin
                exp_stats[meta_map[i]]++;
            end
        end
        if (row.dm.valid && row.dm.ready) begin
            exp_stats[DM_IN]++;
            case (row.dm.flag)
                PKT_ETH:  exp_stats[PKT_ETH_CNT]++;
                PKT_DROP: exp_stats[PKT_DROP_CNT]++;
                PKT_PCIE: exp_stats[PKT_PCIE_CNT]++;
                default: ;
            endcase
        end
        if (stat_word_t'(row.fill.parser_fifo) > exp_stats[MAX_PARSER_FIFO])
            exp_stats[MAX_PARSER_FIFO] = stat_word_t'(row.fill.parser_fifo);
        if (stat_word_t'(row.fill.fd_out_fifo) > exp_stats[MAX_FD_OUT_FIFO])
            exp_stats[MAX_FD_OUT_FIFO] = stat_word_t'(row.fill.fd_out_fifo);
        if (stat_word_t'(row.fill.dm2pcie_fifo) > exp_stats[MAX_DM2PCIE_FIFO])
            exp_stats[MAX_DM2PCIE_FIFO] = stat_word_t'(row.fill.dm2pcie_fifo);
    endfunction

    ////////////////////////////////////////////////////
    // Status reads
    ////////////////////////////////////////////////////
    task automatic queue_read(input logic [29:0] addr);
        slots.push_back('{rd: 1'b1, addr: addr});
        num_reads++;
    endtask

    task automatic insert_gap(input int n);
        for (int i = 0; i < n; i++) begin
            slots.push_back('{rd: 1'b0, addr: 30'd0});
        end
    endtask

    function automatic stat_word_t expected_read(input logic [29:0] addr);
        int idx;
        idx = int'(addr[REG_IDX_W-1:0]);
        return (idx < NUM_STATS) ? exp_stats[idx] : UNKNOWN_READ_VALUE;
    endfunction

    // Data is due three cycles after its read strobe
    task automatic run_reads(input int first, input int last);
        read_slot_t s;
        logic       due;
        for (int k = 0; k < last - first + 6; k++) begin
            @(posedge clk_status);
            #1;
            due = (k >= 3) && (first + k - 3 < last);
            if (due) begin
                s   = slots[first + k - 3];
                due = s.rd && (s.addr[29 -: STAT_AWIDTH] == TOP_REG);
            end
            if (due && status_readdata_valid !== 1'b1) begin
                errors++;
                $display("At %0d ns no read data came back for address %h", $time, s.addr);
            end else if (!due && status_readdata_valid !== 1'b0) begin
                errors++;
                $display("At %0d ns read data was flagged valid with no read due", $time);
            end else if (due) begin
                check_value($sformatf("read of address %h", s.addr), status_readdata,
                            expected_read(s.addr));
            end
            if (first + k < last) begin
                status_read = slots[first + k].rd;
                status_addr = slots[first + k].addr;
            end else begin
                status_read = 1'b0;
                status_addr = '0;
            end
        end
    endtask

    initial begin
        cycles = 0;
        #1;
        while (cycles < cycle_limit) begin
            @(posedge clk_status);
            cycles++;
        end
        $display("Simulation timed out after %0d cycles", cycles);
        $display("tests failed");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        cur_row     = '0;
        status_addr = '0;
        status_read = 1'b0;
        seed        = 32'h108c_fcef;
        errors      = 0;
        num_reads   = 0;
        for (int i = 0; i < NUM_STATS; i++) begin
            exp_stats[i] = '0;
        end
        build_rows();
        for (int i = 0; i < NUM_STATS; i++) begin
            queue_read(30'(i));
        end
        reset_reads_end = slots.size();
        for (int i = 0; i < NUM_STATS; i++) begin
            queue_read(30'(i));
            insert_gap(1);
        end
        queue_read(30'd20);
        insert_gap(1);
        // Other block select stays silent
        queue_read({2'b01, 28'd5});
        insert_gap(6);
        queue_read(30'(PKT_ETH_CNT));
        queue_read(30'(PKT_DROP_CNT));
        queue_read(30'(DM_IN));
        cycle_limit = NUM_ROWS + 4 * num_reads + 50;

        repeat (10) @(posedge clk_status);
        #1;
        rst = 1'b0;
        repeat (3) begin
            @(posedge clk_status);
            #1;
            if (status_readdata_valid !== 1'b0) begin
                errors++;
                $display("At %0d ns read data was flagged valid before any read", $time);
            end
        end
        run_reads(0, reset_reads_end);

        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk_status);
            #1;
            cur_row = rows[i];
            update_model(rows[i]);
        end
        @(posedge clk_status);
        #1;
        cur_row = '0;
        run_reads(reset_reads_end, slots.size());

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: verilog/pipeline_stats.sv
`timescale 1ns/1ps

module pipeline_stats (
    input  logic                    clk_status,
    input  logic                    rst,
    input  stats_pkg::pkt_tap_t     eth_in,
    input  stats_pkg::pkt_tap_t     eth_out,
    input  stats_pkg::pkt_tap_t     pcie_pkt,
    input  stats_pkg::meta_tap_t    incomp_meta,
    input  stats_pkg::meta_tap_t    parser_meta,
    input  stats_pkg::meta_tap_t    fd_in,
    input  stats_pkg::meta_tap_t    fd_out,
    input  stats_pkg::meta_tap_t    emptylist_in,
    input  stats_pkg::meta_tap_t    emptylist_out,
    input  stats_pkg::meta_tap_t    pcie_meta,
    input  stats_pkg::dm_meta_tap_t dm_meta,
    input  stats_pkg::fill_levels_t fill_levels,
    input  logic [29:0]             status_addr,
    input  logic                    status_read,
    output stats_pkg::stat_word_t   status_readdata,
    output logic                    status_readdata_valid
);
    import stats_pkg::*;

    pkt_tap_t   [NUM_PKT_TAPS-1:0]  pkt_taps;
    meta_tap_t  [NUM_META_TAPS-1:0] meta_taps;
    stat_word_t [NUM_PKT_TAPS-1:0]  pkt_counts;
    stat_word_t [NUM_META_TAPS-1:0] meta_counts;
    stat_word_t                     dm_in_count;
    stat_word_t                     eth_count;
    stat_word_t                     drop_count;
    stat_word_t                     pcie_count;
    fill_levels_t                   peaks;
    stat_word_t [NUM_STATS-1:0]     stats;

    // Bank slots, packet then meta
    assign pkt_taps  = {pcie_pkt, eth_out, eth_in};
    assign meta_taps = {pcie_meta, emptylist_out, emptylist_in, fd_out, fd_in,
                        parser_meta, incomp_meta};

    handshake_counter_bank counter_bank_i (
        .clk_status  (clk_status),
        .rst         (rst),
        .pkt_taps    (pkt_taps),
        .meta_taps   (meta_taps),
        .pkt_counts  (pkt_counts),
        .meta_counts (meta_counts)
    );

    pkt_flag_classifier flag_classifier_i (
        .clk_status  (clk_status),
        .rst         (rst),
        .dm_meta     (dm_meta),
        .dm_in_count (dm_in_count),
        .eth_count   (eth_count),
        .drop_count  (drop_count),
        .pcie_count  (pcie_count)
    );

    fill_watermark watermark_i (
        .clk_status (clk_status),
        .rst        (rst),
        .levels     (fill_levels),
        .peaks      (peaks)
    );

    ////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////
    always_comb begin
        stats[IN_PKT]           = pkt_counts[0];
        stats[OUT_PKT]          = pkt_counts[1];
        stats[INCOMP_META]      = meta_counts[0];
        stats[PARSER_META]      = meta_counts[1];
        stats[MAX_PARSER_FIFO]  = stat_word_t'(peaks.parser_fifo);
        stats[FD_IN]            = meta_counts[2];
        stats[FD_OUT]           = meta_counts[3];
        stats[MAX_FD_OUT_FIFO]  = stat_word_t'(peaks.fd_out_fifo);
        stats[DM_IN]            = dm_in_count;
        stats[EMPTYLIST_IN]     = meta_counts[4];
        stats[EMPTYLIST_OUT]    = meta_counts[5];
        stats[PKT_ETH_CNT]      = eth_count;
        stats[PKT_DROP_CNT]     = drop_count;
        stats[PKT_PCIE_CNT]     = pcie_count;
        stats[MAX_DM2PCIE_FIFO] = stat_word_t'(peaks.dm2pcie_fifo);
        stats[PCIE_PKT]         = pkt_counts[2];
        stats[PCIE_META]        = meta_counts[6];
    end

    status_regfile regfile_i (
        .clk_status            (clk_status),
        .rst                   (rst),
        .stats                 (stats),
        .status_addr           (status_addr),
        .status_read           (status_read),
        .status_readdata       (status_readdata),
        .status_readdata_valid (status_readdata_valid)
    );

endmodule

// File: verilog/status_regfile.sv
`timescale 1ns/1ps

module status_regfile (
    input  logic                                             clk_status,
    input  logic                                             rst,
    input  stats_pkg::stat_word_t [stats_pkg::NUM_STATS-1:0] stats,
    input  logic [29:0]                                      status_addr,
    input  logic                                             status_read,
    output stats_pkg::stat_word_t                            status_readdata,
    output logic                                             status_readdata_valid
);
    import stats_pkg::*;

    // Stage 1, sampled request
    logic                   read_r;
    logic [STAT_AWIDTH-1:0] sel_r;
    stat_idx_e              idx_r;

    // Stage 2, decoded result
    logic                   valid_top;
    stat_word_t             data_top;

    ////////////////////////////////////////////////////
    // Request register
    ////////////////////////////////////////////////////
    always_ff @(posedge clk_status) begin
        if (rst) begin
            read_r <= 1'b0;
        end else begin
            read_r <= status_read;
        end
    end

    always_ff @(posedge clk_status) begin
        sel_r <= status_addr[29 -: STAT_AWIDTH];
        idx_r <= stat_idx_e'(status_addr[REG_IDX_W-1:0]);
    end

    ////////////////////////////////////////////////////
    // Decode and register map mux
    ////////////////////////////////////////////////////
    always_ff @(posedge clk_status) begin
        if (rst) begin
            valid_top <= 1'b0;
        end else begin
            valid_top <= read_r && (sel_r == TOP_REG);
        end
    end

    always_ff @(posedge clk_status) begin
        if (read_r && (sel_r == TOP_REG)) begin
            if (int'(idx_r) < NUM_STATS) begin
                data_top <= stats[idx_r];
            end else begin
                data_top <= UNKNOWN_READ_VALUE;
            end
        end
    end

    // Output register
    always_ff @(posedge clk_status) begin
        if (rst) begin
            status_readdata_valid <= 1'b0;
        end else begin
            status_readdata_valid <= valid_top;
        end
    end

    always_ff @(posedge clk_status) begin
        if (valid_top) begin
            status_readdata <= data_top;
        end
    end

    // Fixed latency back to the strobe
    a_read_latency: assert property (
        @(posedge clk_status) disable iff (rst)
        status_readdata_valid |-> $past(status_read, 3)
    ) else $error("readdata_valid without a read three cycles earlier");

endmodule

// File: verilog/fill_watermark.sv
`timescale 1ns/1ps

module fill_watermark (
    input  logic                    clk_status,
    input  logic                    rst,
    input  stats_pkg::fill_levels_t levels,
    output stats_pkg::fill_levels_t peaks
);
    import stats_pkg::*;

    function automatic fill_level_t max_level(fill_level_t cur, fill_level_t peak);
        return (cur > peak) ? cur : peak;
    endfunction

    // Running maxima, cleared only by reset
    always_ff @(posedge clk_status) begin
        if (rst) begin
            peaks <= '0;
        end else begin
            peaks.parser_fifo  <= max_level(levels.parser_fifo, peaks.parser_fifo);
            peaks.fd_out_fifo  <= max_level(levels.fd_out_fifo, peaks.fd_out_fifo);
            peaks.dm2pcie_fifo <= max_level(levels.dm2pcie_fifo, peaks.dm2pcie_fifo);
        end
    end

    ////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////
    a_peak_monotonic: assert property (
        @(posedge clk_status) disable iff (rst)
        !$past(rst) |->
            (peaks.parser_fifo  >= $past(peaks.parser_fifo)) &&
            (peaks.fd_out_fifo  >= $past(peaks.fd_out_fifo)) &&
            (peaks.dm2pcie_fifo >= $past(peaks.dm2pcie_fifo))
    ) else $error("fill watermark decreased");

endmodule

// File: verilog/pkt_flag_classifier.sv
`timescale 1ns/1ps

module pkt_flag_classifier (
    input  logic                    clk_status,
    input  logic                    rst,
    input  stats_pkg::dm_meta_tap_t dm_meta,
    output stats_pkg::stat_word_t   dm_in_count,
    output stats_pkg::stat_word_t   eth_count,
    output stats_pkg::stat_word_t   drop_count,
    output stats_pkg::stat_word_t   pcie_count
);
    import stats_pkg::*;

    logic                accept;
    logic [STAT_W+1:0]   disp_sum;

    assign accept = dm_meta.valid & dm_meta.ready;

    always_ff @(posedge clk_status) begin
        if (rst) begin
            dm_in_count <= '0;
            eth_count   <= '0;
            drop_count  <= '0;
            pcie_count  <= '0;
        end else if (accept) begin
            dm_in_count <= dm_in_count + 1'b1;
            case (dm_meta.flag)
                PKT_ETH:  eth_count  <= eth_count + 1'b1;
                PKT_DROP: drop_count <= drop_count + 1'b1;
                PKT_PCIE: pcie_count <= pcie_count + 1'b1;
                // Reserved flag goes into the total only
                default: ;
            endcase
        end
    end

    always_comb begin
        disp_sum = {2'b00, eth_count} + {2'b00, drop_count} + {2'b00, pcie_count};
    end

    ////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////
    a_split_bounded: assert property (
        @(posedge clk_status) disable iff (rst)
        disp_sum <= {2'b00, dm_in_count}
    ) else $error("flag split exceeds data-mover total");

endmodule

// File: verilog/handshake_counter_bank.sv
`timescale 1ns/1ps

module handshake_counter_bank (
    input  logic                                                 clk_status,
    input  logic                                                 rst,
    input  stats_pkg::pkt_tap_t   [stats_pkg::NUM_PKT_TAPS-1:0]  pkt_taps,
    input  stats_pkg::meta_tap_t  [stats_pkg::NUM_META_TAPS-1:0] meta_taps,
    output stats_pkg::stat_word_t [stats_pkg::NUM_PKT_TAPS-1:0]  pkt_counts,
    output stats_pkg::stat_word_t [stats_pkg::NUM_META_TAPS-1:0] meta_counts
);
    import stats_pkg::*;

    // Packet taps in the low slots, meta taps above
    logic [NUM_PKT_TAPS+NUM_META_TAPS-1:0]       hit;
    stat_word_t [NUM_PKT_TAPS+NUM_META_TAPS-1:0] counts;

    always_comb begin
        for (int i = 0; i < NUM_PKT_TAPS; i++) begin
            // Only the accepted end-of-packet beat
            hit[i] = pkt_taps[i].valid & pkt_taps[i].ready & pkt_taps[i].eop;
        end
        for (int j = 0; j < NUM_META_TAPS; j++) begin
            hit[NUM_PKT_TAPS+j] = meta_taps[j].valid & meta_taps[j].ready;
        end
    end

    always_ff @(posedge clk_status) begin
        if (rst) begin
            counts <= '0;
        end else begin
            for (int k = 0; k < NUM_PKT_TAPS + NUM_META_TAPS; k++) begin
                if (hit[k]) begin
                    counts[k] <= counts[k] + 1'b1;
                end
            end
        end
    end

    assign pkt_counts  = counts[NUM_PKT_TAPS-1:0];
    assign meta_counts = counts[NUM_PKT_TAPS+NUM_META_TAPS-1:NUM_PKT_TAPS];

    ////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////
    for (genvar g = 0; g < NUM_PKT_TAPS + NUM_META_TAPS; g++) begin : g_step_chk
        // Wrap-safe step of at most one
        a_count_step: assert property (
            @(posedge clk_status) disable iff (rst)
            !$past(rst) |-> stat_word_t'(counts[g] - $past(counts[g])) <= stat_word_t'(1)
        ) else $error("counter %0d stepped by more than one", g);
    end

endmodule

// File: verilog/stats_pkg.sv
package stats_pkg;

    ////////////////////////////////////////////////////
    // Widths and status bus fields
    ////////////////////////////////////////////////////
    localparam int STAT_W      = 32;
    localparam int STAT_AWIDTH = 2;
    localparam int REG_IDX_W   = 8;
    localparam int FILL_W      = 10;

    localparam logic [STAT_AWIDTH-1:0] TOP_REG = '0;

    localparam int NUM_STATS     = 17;
    localparam int NUM_PKT_TAPS  = 3;
    localparam int NUM_META_TAPS = 7;

    typedef logic [STAT_W-1:0] stat_word_t;
    typedef logic [FILL_W-1:0] fill_level_t;

    // Returned for an unmapped index inside this block
    localparam stat_word_t UNKNOWN_READ_VALUE = 32'h345;

    // Data-mover disposition, value 3 unused
    typedef enum logic [1:0] {
        PKT_ETH  = 2'd0,
        PKT_DROP = 2'd1,
        PKT_PCIE = 2'd2
    } pkt_flag_e;

    // Register map
    typedef enum logic [REG_IDX_W-1:0] {
        IN_PKT           = 8'd0,
        OUT_PKT          = 8'd1,
        INCOMP_META      = 8'd2,
        PARSER_META      = 8'd3,
        MAX_PARSER_FIFO  = 8'd4,
        FD_IN            = 8'd5,
        FD_OUT           = 8'd6,
        MAX_FD_OUT_FIFO  = 8'd7,
        DM_IN            = 8'd8,
        EMPTYLIST_IN     = 8'd9,
        EMPTYLIST_OUT    = 8'd10,
        PKT_ETH_CNT      = 8'd11,
        PKT_DROP_CNT     = 8'd12,
        PKT_PCIE_CNT     = 8'd13,
        MAX_DM2PCIE_FIFO = 8'd14,
        PCIE_PKT         = 8'd15,
        PCIE_META        = 8'd16
    } stat_idx_e;

    ////////////////////////////////////////////////////
    // Stream taps
    ////////////////////////////////////////////////////
    typedef struct packed {
        logic valid;
        logic ready;
        logic eop;
    } pkt_tap_t;

    typedef struct packed {
        logic valid;
        logic ready;
    } meta_tap_t;

    typedef struct packed {
        logic      valid;
        logic      ready;
        pkt_flag_e flag;
    } dm_meta_tap_t;

    typedef struct packed {
        fill_level_t parser_fifo;
        fill_level_t fd_out_fifo;
        fill_level_t dm2pcie_fifo;
    } fill_levels_t;

endpackage
